//--- bram_256x176.sv
// simple dual-port block RAM, port a writes and port b reads, one clock.
// read is registered and holds between reads; same-address access reads old data.
// array has no reset, contents are unknown until written.
`default_nettype none

module bram_256x176 (
   input  wire logic                 memclk,
   input  wire logic                 ena,       // write strobe.
   input  sram_pkg::bram_lane_t      wea,       // per byte lane.
   input  sram_pkg::sram_addr_t      addra,
   input  sram_pkg::bram_data_t      dina,
   input  wire logic                 enb,       // read strobe.
   input  sram_pkg::sram_addr_t      addrb,
   output sram_pkg::bram_data_t      doutb
);

   sram_pkg::bram_data_t mem [sram_pkg::sram_depth];

   // write under lane enables.
   always_ff @(posedge memclk) begin
      if (ena) begin
         for (int l = 0; l < sram_pkg::num_fields; l++) begin
            if (wea[l]) begin
               mem[addra][l*sram_pkg::slot_w +: sram_pkg::slot_w] <=
                  dina[l*sram_pkg::slot_w +: sram_pkg::slot_w];
            end
         end
      end
   end

   // registered read, sees the pre-write contents.
   always_ff @(posedge memclk) begin
      if (enb) begin
         doutb <= mem[addrb];                 // held until next enb.
      end
   end

   // a write to an unknown address would smear the whole array.
   a_addra_known: assert property (@(posedge memclk) ena |-> !$isunknown(addra))
      else $error("bram_256x176: write with unknown address");

   // read address likewise.
   a_addrb_known: assert property (@(posedge memclk) enb |-> !$isunknown(addrb))
      else $error("bram_256x176: read with unknown address");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with verilator, result taken from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sram_subsys \
   -f sram_subsys.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
exit 0

//--- sram_2rw_256x66.sv
// 256x66 macro on a 256x176 bram, port a reads, port b writes under bit mask.
// only the lowest mask bit of each field counts, the rest are ignored.
// any BIST command takes over both ports, functional requests are dropped.
`default_nettype none

module sram_2rw_256x66 (
   input  wire logic               memclk,
   input  wire logic               rst,
   input  wire logic               ce_a,
   input  sram_pkg::sram_addr_t    aa,
   input  wire logic               rdwen_a,       // high to read.
   input  wire logic               ce_b,
   input  sram_pkg::sram_addr_t    ab,
   input  wire logic               rdwen_b,       // low to write.
   input  sram_pkg::sram_data_t    bw_b,
   input  sram_pkg::sram_data_t    din_b,
   output sram_pkg::sram_data_t    douta,
   input  sram_pkg::bist_op_e      bist_command,
   input  sram_pkg::bist_bus_t     bist_din,
   output sram_pkg::bist_bus_t     bist_dout
);

   logic                  bist_active;
   logic                  write_en;
   logic                  read_en;
   sram_pkg::sram_addr_t  wr_addr;
   sram_pkg::sram_addr_t  rd_addr;
   sram_pkg::sram_data_t  wr_data;
   sram_pkg::sram_data_t  wr_mask;
   sram_pkg::bram_lane_t  wen_mask;
   sram_pkg::bram_data_t  data_in;
   sram_pkg::bram_data_t  data_out;
   sram_pkg::sram_data_t  rd_word;
   logic                  dout_valid;

   assign bist_active = (bist_command != sram_pkg::BIST_IDLE);

   // request select, BIST wins.
   always_comb begin
      if (bist_active) begin
         write_en = (bist_command == sram_pkg::BIST_WRITE);
         read_en  = (bist_command == sram_pkg::BIST_READ);
         wr_addr  = bist_din[7:0];
         rd_addr  = bist_din[7:0];
         wr_data  = sram_pkg::replicate_pattern(bist_din[15:8]);
         wr_mask  = '1;                                   // all lanes.
      end else begin
         write_en = ce_b & ~rdwen_b;
         read_en  = ce_a & rdwen_a;
         wr_addr  = ab;
         rd_addr  = aa;
         wr_data  = din_b;
         wr_mask  = bw_b;
      end
   end

   // pack each field into the low bits of its slot.
   always_comb begin
      data_in = '0;                                       // slot padding.
      for (int f = 0; f < sram_pkg::num_fields; f++) begin
         for (int b = 0; b < sram_pkg::slot_w; b++) begin
            if (b < sram_pkg::field_width[f]) begin
               data_in[f*sram_pkg::slot_w + b] = wr_data[sram_pkg::field_lsb[f] + b];
            end
         end
      end
   end

   // lane enable follows the field's lowest mask bit only.
   always_comb begin
      for (int f = 0; f < sram_pkg::num_fields; f++) begin
         wen_mask[f] = wr_mask[sram_pkg::field_lsb[f]];
      end
   end

   // unpack the registered read word.
   always_comb begin
      rd_word = '0;
      for (int f = 0; f < sram_pkg::num_fields; f++) begin
         for (int b = 0; b < sram_pkg::slot_w; b++) begin
            if (b < sram_pkg::field_width[f]) begin
               rd_word[sram_pkg::field_lsb[f] + b] = data_out[f*sram_pkg::slot_w + b];
            end
         end
      end
   end

   // bram output register has no reset, so mask it until the first read.
   always_ff @(posedge memclk) begin
      if (rst) begin
         dout_valid <= 1'b0;
      end else if (read_en) begin
         dout_valid <= 1'b1;
      end
   end

   assign douta = dout_valid ? rd_word : '0;

   // fold shown only on a compare cycle.
   assign bist_dout = (bist_command == sram_pkg::BIST_COMPARE) ?
                      sram_pkg::fold_word(rd_word) : '0;

   bram_256x176 u_bram (
      .memclk (memclk),
      .ena    (write_en),
      .wea    (wen_mask),
      .addra  (wr_addr),
      .dina   (data_in),
      .enb    (read_en),
      .addrb  (rd_addr),
      .doutb  (data_out)
   );

   // compare relies on the word fetched by the read just before it.
   a_cmp_after_read: assert property (@(posedge memclk) disable iff (rst)
      bist_command == sram_pkg::BIST_COMPARE |-> $past(bist_command) == sram_pkg::BIST_READ)
      else $error("sram_2rw_256x66: compare without preceding read");

endmodule

`default_nettype wire

//--- sram_bist_march.sv
// march BIST: write 0x55 all, read/compare all, write 0xAA all, read/compare all.
// a read takes two cycles, read then compare on the folded word.
// start is taken only when idle or done; done and fail clear on the next start.
`default_nettype none

module sram_bist_march (
   input  wire logic               memclk,
   input  wire logic               rst,
   input  wire logic               bist_start,
   output sram_pkg::bist_op_e      bist_command,
   output sram_pkg::bist_bus_t     bist_din,
   input  sram_pkg::bist_bus_t     bist_dout,
   output logic                    bist_done,
   output logic                    bist_fail
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WRITE,
      ST_READ,
      ST_COMPARE,
      ST_DONE
   } march_state_e;

   march_state_e          state;
   sram_pkg::sram_addr_t  addr;
   logic                  pat_sel;          // 0 first pass, 1 second.
   logic [7:0]            pattern;
   sram_pkg::bist_bus_t   expected_fold;
   logic                  last_addr;

   assign pattern       = pat_sel ? sram_pkg::pattern_b : sram_pkg::pattern_a;
   assign expected_fold = sram_pkg::fold_word(sram_pkg::replicate_pattern(pattern));
   assign last_addr     = (addr == sram_pkg::sram_addr_t'(sram_pkg::sram_depth - 1));

   // command decode from state.
   always_comb begin
      case (state)
         ST_WRITE:   bist_command = sram_pkg::BIST_WRITE;
         ST_READ:    bist_command = sram_pkg::BIST_READ;
         ST_COMPARE: bist_command = sram_pkg::BIST_COMPARE;
         default:    bist_command = sram_pkg::BIST_IDLE;
      endcase
   end

   assign bist_din = (state == ST_IDLE || state == ST_DONE) ? '0 : {pattern, addr};

   always_ff @(posedge memclk) begin
      if (rst) begin
         state     <= ST_IDLE;
         addr      <= '0;
         pat_sel   <= 1'b0;
         bist_done <= 1'b0;
         bist_fail <= 1'b0;
      end else begin
         case (state)
            ST_IDLE, ST_DONE: begin
               if (bist_start) begin            // (re)start the march.
                  state     <= ST_WRITE;
                  addr      <= '0;
                  pat_sel   <= 1'b0;
                  bist_done <= 1'b0;
                  bist_fail <= 1'b0;
               end
            end
            ST_WRITE: begin
               addr <= addr + 1'b1;             // wraps to 0 after last.
               if (last_addr) state <= ST_READ;
            end
            ST_READ: begin
               state <= ST_COMPARE;
            end
            ST_COMPARE: begin
               if (bist_dout != expected_fold) begin
                  bist_fail <= 1'b1;            // sticky.
               end
               addr <= addr + 1'b1;
               if (!last_addr) begin
                  state <= ST_READ;
               end else if (!pat_sel) begin
                  pat_sel <= 1'b1;              // second pass.
                  state   <= ST_WRITE;
               end else begin
                  state     <= ST_DONE;
                  bist_done <= 1'b1;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // once done, the macro gets its functional ports back.
   a_idle_when_done: assert property (@(posedge memclk) disable iff (rst)
      bist_done |-> bist_command == sram_pkg::BIST_IDLE)
      else $error("sram_bist_march: command issued while done");

endmodule

`default_nettype wire

//--- sram_pkg.sv
// shared widths, types, field layout and BIST op encoding of the 256x66 macro.
// fold rule: the 66-bit word is XORed in 16-bit chunks, top chunk zero padded.
// pattern rule: the BIST pattern byte repeats across 66 bits, cut at the top.
`default_nettype none

package sram_pkg;

   localparam int sram_depth  = 256;
   localparam int sram_addr_w = 8;
   localparam int sram_data_w = 66;
   localparam int num_fields  = 22;                 // one field per bram slot.
   localparam int slot_w      = 8;                  // bram byte lane.
   localparam int bram_data_w = num_fields * slot_w;
   localparam int bist_bus_w  = 16;
   localparam int fold_chunks = (sram_data_w + bist_bus_w - 1) / bist_bus_w;

   localparam logic [7:0] pattern_a = 8'h55;        // first march pass.
   localparam logic [7:0] pattern_b = 8'hAA;        // second march pass.

   // field layout from the lsb: {6,4,1,2,2} x4, then 4 and 2.
   localparam int field_lsb [num_fields] = '{
      0, 6, 10, 11, 13, 15, 21, 25, 26, 28, 30,
      36, 40, 41, 43, 45, 51, 55, 56, 58, 60, 64};
   localparam int field_width [num_fields] = '{
      6, 4, 1, 2, 2, 6, 4, 1, 2, 2, 6,
      4, 1, 2, 2, 6, 4, 1, 2, 2, 4, 2};

   typedef logic [sram_addr_w-1:0] sram_addr_t;
   typedef logic [sram_data_w-1:0] sram_data_t;    // data word and bit mask.
   typedef logic [bram_data_w-1:0] bram_data_t;
   typedef logic [num_fields-1:0]  bram_lane_t;
   typedef logic [bist_bus_w-1:0]  bist_bus_t;     // cmd: {pattern, addr}.

   typedef enum logic [1:0] {
      BIST_IDLE    = 2'd0,
      BIST_WRITE   = 2'd1,
      BIST_READ    = 2'd2,
      BIST_COMPARE = 2'd3
   } bist_op_e;

   // pattern byte spread over the whole word.
   function automatic sram_data_t replicate_pattern(input logic [7:0] pat);
      sram_data_t r;
      for (int i = 0; i < sram_data_w; i++) r[i] = pat[i % 8];
      return r;
   endfunction

   // xor fold of a word down to the bist bus width.
   function automatic bist_bus_t fold_word(input sram_data_t w);
      logic [fold_chunks*bist_bus_w-1:0] padded;
      bist_bus_t acc;
      padded = '0;
      padded[sram_data_w-1:0] = w;                  // zero pad on top chunk.
      acc = '0;
      for (int c = 0; c < fold_chunks; c++) acc ^= padded[c*bist_bus_w +: bist_bus_w];
      return acc;
   endfunction

endpackage

`default_nettype wire

//--- sram_subsys.f
sram_pkg.sv
bram_256x176.sv
sram_2rw_256x66.sv
sram_bist_march.sv
sram_subsys_top.sv
tb_sram_subsys.sv

//--- sram_subsys_top.sv
// macro wrapper plus its march BIST engine.
// functional ports are ignored while a march runs.
`default_nettype none

module sram_subsys_top (
   input  wire logic               memclk,
   input  wire logic               rst,
   input  wire logic               ce_a,
   input  sram_pkg::sram_addr_t    aa,
   input  wire logic               rdwen_a,
   input  wire logic               ce_b,
   input  sram_pkg::sram_addr_t    ab,
   input  wire logic               rdwen_b,
   input  sram_pkg::sram_data_t    bw_b,
   input  sram_pkg::sram_data_t    din_b,
   output sram_pkg::sram_data_t    douta,
   input  wire logic               bist_start,   // one-cycle pulse.
   output logic                    bist_done,
   output logic                    bist_fail
);

   sram_pkg::bist_op_e   bist_command;
   sram_pkg::bist_bus_t  bist_din;
   sram_pkg::bist_bus_t  bist_dout;

   sram_bist_march u_bist (
      .memclk       (memclk),
      .rst          (rst),
      .bist_start   (bist_start),
      .bist_command (bist_command),
      .bist_din     (bist_din),
      .bist_dout    (bist_dout),
      .bist_done    (bist_done),
      .bist_fail    (bist_fail)
   );

   sram_2rw_256x66 u_sram (
      .memclk       (memclk),
      .rst          (rst),
      .ce_a         (ce_a),
      .aa           (aa),
      .rdwen_a      (rdwen_a),
      .ce_b         (ce_b),
      .ab           (ab),
      .rdwen_b      (rdwen_b),
      .bw_b         (bw_b),
      .din_b        (din_b),
      .douta        (douta),
      .bist_command (bist_command),
      .bist_din     (bist_din),
      .bist_dout    (bist_dout)
   );

endmodule

`default_nettype wire

//--- tb_sram_subsys.sv
// drives the subsystem from a fixed-seed xorshift stream against a field-level model.
// every address is written once before any read, so the model never holds unknowns.
// the march is only checked to pass since no faults are injected.
`default_nettype none

module tb_sram_subsys;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_ops      = 200;            // per random test.
   localparam int bist_timeout = 5000;           // march needs about 1.5k cycles.
   // field widths from the lsb are {6,4,1,2,2} x4 then 4 and 2.
   localparam int field_w [22] = '{6, 4, 1, 2, 2, 6, 4, 1, 2, 2, 6,
                                   4, 1, 2, 2, 6, 4, 1, 2, 2, 4, 2};

   logic                  memclk = 1'b0;
   logic                  rst;
   logic                  ce_a;
   sram_pkg::sram_addr_t  aa;
   logic                  rdwen_a;
   logic                  ce_b;
   sram_pkg::sram_addr_t  ab;
   logic                  rdwen_b;
   sram_pkg::sram_data_t  bw_b;
   sram_pkg::sram_data_t  din_b;
   sram_pkg::sram_data_t  douta;
   logic                  bist_start;
   logic                  bist_done;
   logic                  bist_fail;

   sram_pkg::sram_data_t  model [256];           // reference contents.
   logic [31:0]           rng;
   int                    n_checks;
   int                    n_errors;

   always #5 memclk = ~memclk;                   // 10 ns period.

   sram_subsys_top u_sram_subsys_top (
      .memclk     (memclk),
      .rst        (rst),
      .ce_a       (ce_a),
      .aa         (aa),
      .rdwen_a    (rdwen_a),
      .ce_b       (ce_b),
      .ab         (ab),
      .rdwen_b    (rdwen_b),
      .bw_b       (bw_b),
      .din_b      (din_b),
      .douta      (douta),
      .bist_start (bist_start),
      .bist_done  (bist_done),
      .bist_fail  (bist_fail)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic draw(output logic [31:0] r);
      rng = xorshift32(rng);
      r   = rng;
   endtask

   // 66 random bits from three draws.
   task automatic draw_word(output sram_pkg::sram_data_t w);
      logic [31:0] lo;
      logic [31:0] mid;
      logic [31:0] hi;
      draw(lo);
      draw(mid);
      draw(hi);
      w = {hi[1:0], mid, lo};
   endtask

   // a field takes din only when its lowest mask bit is set.
   function automatic sram_pkg::sram_data_t apply_write(input sram_pkg::sram_data_t old_w,
                                                       input sram_pkg::sram_data_t din,
                                                       input sram_pkg::sram_data_t mask);
      sram_pkg::sram_data_t r;
      int lsb;
      r   = old_w;
      lsb = 0;
      for (int f = 0; f < 22; f++) begin
         if (mask[lsb]) begin
            for (int b = 0; b < field_w[f]; b++) r[lsb + b] = din[lsb + b];
         end
         lsb += field_w[f];
      end
      return r;
   endfunction

   // one bit set at each field's lsb.
   function automatic sram_pkg::sram_data_t field_base_bits();
      sram_pkg::sram_data_t r;
      int lsb;
      r   = '0;
      lsb = 0;
      for (int f = 0; f < 22; f++) begin
         r[lsb] = 1'b1;
         lsb += field_w[f];
      end
      return r;
   endfunction

   // byte repeated over the word with the top cut off.
   function automatic sram_pkg::sram_data_t spread_byte(input logic [7:0] pat);
      logic [71:0] wide;
      wide = {9{pat}};
      return wide[65:0];
   endfunction

   task automatic check_word(input string name, input sram_pkg::sram_data_t exp,
                             input sram_pkg::sram_data_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // port b write with the model following at the same edge.
   task automatic write_word(input sram_pkg::sram_addr_t addr,
                             input sram_pkg::sram_data_t din,
                             input sram_pkg::sram_data_t mask);
      @(negedge memclk);
      ce_b    = 1'b1;
      rdwen_b = 1'b0;
      ab      = addr;
      din_b   = din;
      bw_b    = mask;
      @(negedge memclk);
      ce_b    = 1'b0;
      rdwen_b = 1'b1;
      model[addr] = apply_write(model[addr], din, mask);
   endtask

   // port a read with data checked one cycle later.
   task automatic read_check(input string name, input sram_pkg::sram_addr_t addr);
      @(negedge memclk);
      ce_a    = 1'b1;
      rdwen_a = 1'b1;
      aa      = addr;
      @(negedge memclk);
      ce_a = 1'b0;
      check_word(name, model[addr], douta);
   endtask

   // read and write on one address in one cycle return old data.
   task automatic read_during_write(input sram_pkg::sram_addr_t addr,
                                    input sram_pkg::sram_data_t din);
      sram_pkg::sram_data_t old_w;
      old_w = model[addr];
      @(negedge memclk);
      ce_a    = 1'b1;
      rdwen_a = 1'b1;
      aa      = addr;
      ce_b    = 1'b1;
      rdwen_b = 1'b0;
      ab      = addr;
      din_b   = din;
      bw_b    = '1;
      @(negedge memclk);
      ce_a    = 1'b0;
      ce_b    = 1'b0;
      rdwen_b = 1'b1;
      check_word("same_cycle_old_data", old_w, douta);
      model[addr] = apply_write(model[addr], din, '1);
      read_check("same_cycle_new_data", addr);
   endtask

   initial begin
      logic [31:0]           r;
      sram_pkg::sram_data_t  w;
      sram_pkg::sram_data_t  m;
      sram_pkg::sram_addr_t  a;
      int                    waited;
      rng        = 32'h981b8198;
      n_checks   = 0;
      n_errors   = 0;
      rst        = 1'b1;
      ce_a       = 1'b0;
      aa         = '0;
      rdwen_a    = 1'b1;
      ce_b       = 1'b0;
      ab         = '0;
      rdwen_b    = 1'b1;
      bw_b       = '0;
      din_b      = '0;
      bist_start = 1'b0;
      for (int i = 0; i < 256; i++) model[i] = '0;
      for (int c = 0; c < 8; c++) @(negedge memclk);   // reset hold.
      rst = 1'b0;
      @(negedge memclk);

      check_word("reset_douta", '0, douta);
      check_flag("reset_bist_done", 1'b0, bist_done);
      check_flag("reset_bist_fail", 1'b0, bist_fail);

      // known contents everywhere.
      for (int i = 0; i < 256; i++) begin
         draw_word(w);
         write_word(sram_pkg::sram_addr_t'(i), w, '1);
      end

      for (int n = 0; n < num_ops; n++) begin
         draw(r);
         a = r[7:0];
         draw_word(w);
         write_word(a, w, '1);
         read_check("full_mask_read", a);
      end

      // random masks are mostly uneven inside a field.
      for (int n = 0; n < num_ops; n++) begin
         draw(r);
         a = r[7:0];
         draw_word(w);
         draw_word(m);
         write_word(a, w, m);
         read_check("random_mask_read", a);
      end
      draw_word(w);
      write_word(8'h3c, w, ~field_base_bits());         // nothing lands.
      read_check("upper_mask_bits_only", 8'h3c);
      draw_word(w);
      write_word(8'h3c, w, field_base_bits());          // every field lands.
      read_check("base_mask_bits_only", 8'h3c);

      for (int n = 0; n < 16; n++) begin
         draw(r);
         draw_word(w);
         read_during_write(r[7:0], w);
      end

      @(negedge memclk);
      bist_start = 1'b1;
      @(negedge memclk);
      bist_start = 1'b0;
      waited = 0;
      while (!bist_done && waited < bist_timeout) begin
         @(negedge memclk);
         waited++;
      end
      if (!bist_done) begin
         n_errors++;
         $display("bist_done did not rise within %0d cycles", bist_timeout);
      end else begin
         check_flag("bist_fail_after_march", 1'b0, bist_fail);
         for (int i = 0; i < 256; i++) model[i] = spread_byte(8'hAA);   // last pass.
         draw(r);
         read_check("read_after_march", r[7:0]);
         // douta already holds the pattern, so new data shows the ports are back.
         draw_word(w);
         write_word(r[7:0], w, '1);
         read_check("write_after_march", r[7:0]);
      end

      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
